//--- apbI2c.f
apbI2cPkg.sv
creditFifo.sv
apbRegs.sv
i2cEngine.sv
apbI2c.sv
i2cSlaveModel.sv
apbI2cTb.sv

//--- apbI2c.sv
`timescale 1ns/1ns

/*
 * APB I2C master top: register block, transmit and receive queues, byte engine
 */
module apbI2c #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSEL,
	input  logic PENABLE,
	input  logic PWRITE,
	input  apbI2cPkg::apbAddrT PADDR,
	input  apbI2cPkg::apbDataT PWDATA,
	output apbI2cPkg::apbDataT PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic intTx,
	output logic intRx,
	output logic scl,
	output logic sdaOut,
	input  logic sdaIn
);

	// Counters hold 0 to FIFO_DEPTH
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Transmit path
	logic txPush;
	apbI2cPkg::cmdWordT txWriteData;
	logic txCreditReturn;
	logic txValid;
	apbI2cPkg::cmdWordT txHeadWord;
	logic txPop;

	// Receive path
	logic rxPush;
	apbI2cPkg::rxByteT rxPushByte;
	logic rxPop;
	apbI2cPkg::rxByteT rxHeadByte;
	logic [CNT_W-1:0] rxLevel;
	logic rxCreditReturn;

	// Configuration and engine status
	apbI2cPkg::i2cRegT configReg;
	apbI2cPkg::i2cRegT timeoutReg;
	logic nackSeen;
	logic timeoutSeen;
	logic busy;

	apbRegs #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CNT_W(CNT_W)
	) regs (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.txCreditReturn(txCreditReturn),
		.rxHeadByte(rxHeadByte),
		.rxLevel(rxLevel),
		.nackSeen(nackSeen),
		.timeoutSeen(timeoutSeen),
		.busy(busy),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.txPush(txPush),
		.txWriteData(txWriteData),
		.rxPop(rxPop),
		.configReg(configReg),
		.timeoutReg(timeoutReg),
		.intTx(intTx),
		.intRx(intRx)
	);

	// Command words toward the engine, level tracked by the APB credits
	creditFifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CNT_W(CNT_W),
		.WIDTH($bits(apbI2cPkg::cmdWordT))
	) txFifo (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.push(txPush),
		.pushData(txWriteData),
		.pop(txPop),
		.headData(txHeadWord),
		.valid(txValid),
		.level(),
		.creditReturn(txCreditReturn)
	);

	// Received bytes toward the APB side
	creditFifo #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CNT_W(CNT_W),
		.WIDTH($bits(apbI2cPkg::rxByteT))
	) rxFifo (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.push(rxPush),
		.pushData(rxPushByte),
		.pop(rxPop),
		.headData(rxHeadByte),
		.valid(),
		.level(rxLevel),
		.creditReturn(rxCreditReturn)
	);

	i2cEngine #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.CNT_W(CNT_W)
	) engine (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.txValid(txValid),
		.txHeadWord(txHeadWord),
		.rxCreditReturn(rxCreditReturn),
		.configReg(configReg),
		.timeoutReg(timeoutReg),
		.sdaIn(sdaIn),
		.txPop(txPop),
		.rxPush(rxPush),
		.rxPushByte(rxPushByte),
		.nackSeen(nackSeen),
		.timeoutSeen(timeoutSeen),
		.busy(busy),
		.scl(scl),
		.sdaOut(sdaOut)
	);

endmodule

//--- apbI2cPkg.sv
/*
 * Shared definitions for the APB I2C master: bus and register vector types,
 * register offsets, command-word flag positions and the engine state type
 */
package apbI2cPkg;

	////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////

	// APB address and data words
	typedef logic [31:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	// CONFIG holds the SCL half-period, TIMEOUT the receive-credit wait
	typedef logic [13:0] i2cRegT;

	// Data byte in the low bits, flags above it
	typedef logic [10:0] cmdWordT;

	// Byte captured from the bus during a read
	typedef logic [7:0] rxByteT;

	////////////////////////////////////////////////////////////////////
	// Register map and command fields
	////////////////////////////////////////////////////////////////////

	localparam apbAddrT ADDR_TX = 32'd0;
	localparam apbAddrT ADDR_RX = 32'd4;
	localparam apbAddrT ADDR_CONFIG = 32'd8;
	localparam apbAddrT ADDR_TIMEOUT = 32'd12;
	localparam apbAddrT ADDR_STATUS = 32'd16;

	// Flag positions inside cmdWordT
	localparam int CMD_START_BIT = 8;
	localparam int CMD_STOP_BIT = 9;
	localparam int CMD_READ_BIT = 10;

	// Byte engine states
	typedef enum logic [3:0] {
		IDLE,
		START,
		BIT_LOW,
		BIT_HIGH,
		ACK_LOW,
		ACK_HIGH,
		STOP_LOW,
		STOP_HIGH,
		WAIT_CREDIT
	} engineStateT;

endpackage

//--- apbI2cTb.sv
`timescale 1ns/1ns

/*
 * Testbench for the APB I2C master: clock, reset, APB transfer table,
 * value check, I2C slave model and cycle watchdog
 */
module apbI2cTb;

	localparam int FIFO_DEPTH = 4;
	// Slowest SCL half-period used, and the receive timeout
	localparam int SLOW_CONFIG = 20;
	localparam int RX_TIMEOUT = 40;
	// Worst command at the slowest CONFIG: 9 bit periods, start, stop, credit wait
	localparam int CMD_CYCLES = 2 * (9 + 1 + 1) * SLOW_CONFIG + RX_TIMEOUT + 32;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_POLL,
		OP_PINS
	} opKindT;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic intTx;
	logic intRx;
	logic scl;
	logic dutSda;
	logic slaveSda;
	logic sdaBus;
	logic dirPush;
	logic dirRead;

	// Stimulus table
	string stepName[$];
	opKindT stepKind[$];
	logic [31:0] stepAddr[$];
	logic [31:0] stepWdata[$];
	logic [31:0] stepExp[$];
	logic [31:0] stepMask[$];
	logic stepErr[$];

	int cycleCount;
	int cycleLimit;

	// Open-drain bus
	assign sdaBus = dutSda & slaveSda;

	apbI2c #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_apbI2c (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.intTx(intTx),
		.intRx(intRx),
		.scl(scl),
		.sdaOut(dutSda),
		.sdaIn(sdaBus)
	);

	i2cSlaveModel slave (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.scl(scl),
		.sda(sdaBus),
		.dirPush(dirPush),
		.dirRead(dirRead),
		.sdaOut(slaveSda)
	);

	initial
	begin
		PCLK = 1'b0;
		forever
			#2 PCLK = !PCLK;
	end

	// Watchdog, limit set once the table is built
	always @(posedge PCLK)
	begin
		cycleCount <= cycleCount + 1;
		if ((cycleLimit != 0) && (cycleCount >= cycleLimit))
		begin
			$display("Timeout: the DUT did not reach the expected state in %0d cycles",
				cycleLimit);
			$display("SIMULATION FAILED");
			$fatal(1, "watchdog expired");
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic addStep(input string name, input opKindT kind, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] expected, input logic [31:0] mask,
		input logic err);
		stepName.push_back(name);
		stepKind.push_back(kind);
		stepAddr.push_back(addr);
		stepWdata.push_back(wdata);
		stepExp.push_back(expected);
		stepMask.push_back(mask);
		stepErr.push_back(err);
	endtask

	// Setup and access phase, sampled mid-cycle in the access phase
	task automatic apbTransfer(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic announce, output logic [31:0] rdata,
		output logic err, output logic ready);
		@(posedge PCLK);
		PSEL <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE <= write;
		PADDR <= addr;
		PWDATA <= wdata;
		dirPush <= announce;
		dirRead <= wdata[10];
		@(posedge PCLK);
		PENABLE <= 1'b1;
		dirPush <= 1'b0;
		@(negedge PCLK);
		rdata = PRDATA;
		err = PSLVERR;
		ready = PREADY;
		@(posedge PCLK);
		PSEL <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////
	// Table and run
	////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		logic err;
		logic ready;
		logic announce;
		logic pollDone;
		PRESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		dirPush = 1'b0;
		dirRead = 1'b0;
		cycleCount = 0;
		cycleLimit = 0;

		// Reset values, then low 14 bits of CONFIG and TIMEOUT
		// Pins from bit 0 up: intTx, intRx, SCL, DUT SDA
		addStep("reset pins", OP_PINS, 0, 0, 32'hD, 32'hF, 1'b0);
		addStep("reset config", OP_READ, 8, 0, 32'h0, 32'hFFFFFFFF, 1'b0);
		addStep("reset timeout", OP_READ, 12, 0, 32'h0, 32'hFFFFFFFF, 1'b0);
		addStep("reset status", OP_READ, 16, 0, FIFO_DEPTH << 4, 32'hFFFFFFFF, 1'b0);
		addStep("write config", OP_WRITE, 8, 32'hFFFFC004, 0, 0, 1'b0);
		addStep("config low bits", OP_READ, 8, 0, 32'h4, 32'hFFFFFFFF, 1'b0);
		addStep("write timeout", OP_WRITE, 12, 32'h0001C028, 0, 0, 1'b0);
		addStep("timeout low bits", OP_READ, 12, 0, RX_TIMEOUT, 32'hFFFFFFFF, 1'b0);

		// Start write of 3C, then a stop read that returns 3C plus one
		addStep("push start write", OP_WRITE, 0, 32'h13C, 0, 0, 1'b0);
		addStep("push stop read", OP_WRITE, 0, 32'h600, 0, 0, 1'b0);
		addStep("wait rx level", OP_POLL, 16, 0, 32'h100, 32'hF00, 1'b0);
		addStep("read rx byte", OP_READ, 4, 0, 32'h3C + 1, 32'hFFFFFFFF, 1'b0);
		addStep("intRx cleared", OP_PINS, 0, 0, 32'h1, 32'h3, 1'b0);
		addStep("wait idle", OP_POLL, 16, 0, 32'h0, 32'h2, 1'b0);

		// Engine takes the first word at once, so the sixth push runs out of credits
		addStep("slow config", OP_WRITE, 8, SLOW_CONFIG, 0, 0, 1'b0);
		addStep("push write 1", OP_WRITE, 0, 32'h011, 0, 0, 1'b0);
		addStep("push write 2", OP_WRITE, 0, 32'h022, 0, 0, 1'b0);
		addStep("push write 3", OP_WRITE, 0, 32'h033, 0, 0, 1'b0);
		addStep("push write 4", OP_WRITE, 0, 32'h044, 0, 0, 1'b0);
		addStep("push write 5", OP_WRITE, 0, 32'h055, 0, 0, 1'b0);
		addStep("push no credit", OP_WRITE, 0, 32'h066, 0, 0, 1'b1);
		addStep("credits zero", OP_READ, 16, 0, 32'h002, 32'hFFFFFFFF, 1'b0);
		addStep("credits back", OP_POLL, 16, 0, FIFO_DEPTH << 4, 32'hF2, 1'b0);
		addStep("status after writes", OP_READ, 16, 0, FIFO_DEPTH << 4, 32'hFFFFFFFF, 1'b0);
		addStep("fast config", OP_WRITE, 8, 4, 0, 0, 1'b0);

		// Slave NACKs FF, error is sticky until STATUS is written
		addStep("push nack write", OP_WRITE, 0, 32'h3FF, 0, 0, 1'b0);
		addStep("wait nack", OP_POLL, 16, 0, 32'h1, 32'h3, 1'b0);
		addStep("clear error", OP_WRITE, 16, 32'h0, 0, 0, 1'b0);
		addStep("error cleared", OP_READ, 16, 0, FIFO_DEPTH << 4, 32'hFFFFFFFF, 1'b0);

		// Reads follow FF, so the slave returns 00 upward, fifth byte times out
		for (int i = 0; i <= FIFO_DEPTH; i++)
			addStep($sformatf("push read %0d", i), OP_WRITE, 0, 32'h400, 0, 0, 1'b0);
		addStep("wait rx full", OP_POLL, 16, 0, (FIFO_DEPTH << 8) | 1, 32'hF03, 1'b0);
		addStep("status rx full", OP_READ, 16, 0, (FIFO_DEPTH << 8) | (FIFO_DEPTH << 4) | 1,
			32'hFFFFFFFF, 1'b0);
		for (int i = 0; i < FIFO_DEPTH; i++)
			addStep($sformatf("pop rx %0d", i), OP_READ, 4, 0, (8'hFF + 1 + i) & 8'hFF,
				32'hFFFFFFFF, 1'b0);
		addStep("pop rx empty", OP_READ, 4, 0, 32'h0, 32'hFFFFFFFF, 1'b1);

		// Unmapped and read-only offsets are rejected without side effects
		addStep("read bad offset", OP_READ, 20, 0, 32'h0, 32'hFFFFFFFF, 1'b1);
		addStep("write bad offset", OP_WRITE, 20, 32'h1234, 0, 0, 1'b1);
		addStep("write rx offset", OP_WRITE, 4, 32'h55, 0, 0, 1'b1);
		addStep("config kept", OP_READ, 8, 0, 32'h4, 32'hFFFFFFFF, 1'b0);
		addStep("timeout kept", OP_READ, 12, 0, RX_TIMEOUT, 32'hFFFFFFFF, 1'b0);
		addStep("status kept", OP_READ, 16, 0, (FIFO_DEPTH << 4) | 1, 32'hFFFFFFFF, 1'b0);

		cycleLimit = 16 + stepName.size() * CMD_CYCLES;

		repeat (16) @(posedge PCLK);
		PRESETn <= 1'b1;
		@(posedge PCLK);

		foreach (stepName[i])
		begin
			case (stepKind[i])
				OP_WRITE:
				begin
					// Only accepted command pushes reach the slave's direction queue
					announce = (stepAddr[i] == 0) && !stepErr[i];
					apbTransfer(1'b1, stepAddr[i], stepWdata[i], announce, rdata, err, ready);
					checkValue({stepName[i], " pready"}, 32'h1, 32'(ready));
					checkValue({stepName[i], " pslverr"}, 32'(stepErr[i]), 32'(err));
				end
				OP_READ:
				begin
					apbTransfer(1'b0, stepAddr[i], 0, 1'b0, rdata, err, ready);
					checkValue({stepName[i], " pready"}, 32'h1, 32'(ready));
					checkValue({stepName[i], " pslverr"}, 32'(stepErr[i]), 32'(err));
					checkValue(stepName[i], stepExp[i], rdata & stepMask[i]);
				end
				OP_POLL:
				begin
					pollDone = 1'b0;
					while (!pollDone)
					begin
						apbTransfer(1'b0, stepAddr[i], 0, 1'b0, rdata, err, ready);
						checkValue({stepName[i], " pready"}, 32'h1, 32'(ready));
						pollDone = ((rdata & stepMask[i]) == stepExp[i]);
					end
				end
				default:
				begin
					@(negedge PCLK);
					checkValue(stepName[i], stepExp[i],
						{28'd0, dutSda, scl, intRx, intTx} & stepMask[i]);
				end
			endcase
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- apbRegs.sv
`timescale 1ns/1ns

/*
 * APB slave: CONFIG and TIMEOUT registers, transmit credit counter,
 * sticky error bit, status readback, PSLVERR decode and interrupts
 */
module apbRegs #(
	parameter int FIFO_DEPTH = 4,
	parameter int CNT_W = 3
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSEL,
	input  logic PENABLE,
	input  logic PWRITE,
	input  apbI2cPkg::apbAddrT PADDR,
	input  apbI2cPkg::apbDataT PWDATA,
	input  logic txCreditReturn,
	input  apbI2cPkg::rxByteT rxHeadByte,
	input  logic [CNT_W-1:0] rxLevel,
	input  logic nackSeen,
	input  logic timeoutSeen,
	input  logic busy,
	output apbI2cPkg::apbDataT PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic txPush,
	output apbI2cPkg::cmdWordT txWriteData,
	output logic rxPop,
	output apbI2cPkg::i2cRegT configReg,
	output apbI2cPkg::i2cRegT timeoutReg,
	output logic intTx,
	output logic intRx
);

	logic access;
	logic writeAccess;
	logic readAccess;
	logic isTx;
	logic isRx;
	logic isConfig;
	logic isTimeout;
	logic isStatus;
	logic mapped;
	logic [CNT_W-1:0] txCredits;
	logic errorFlag;
	apbI2cPkg::apbDataT statusWord;

	////////////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////////////

	// Access phase, always completed in the same cycle
	assign access = PSEL && PENABLE;
	assign writeAccess = access && PWRITE;
	assign readAccess = access && !PWRITE;
	assign PREADY = access;

	assign isTx = (PADDR == apbI2cPkg::ADDR_TX);
	assign isRx = (PADDR == apbI2cPkg::ADDR_RX);
	assign isConfig = (PADDR == apbI2cPkg::ADDR_CONFIG);
	assign isTimeout = (PADDR == apbI2cPkg::ADDR_TIMEOUT);
	assign isStatus = (PADDR == apbI2cPkg::ADDR_STATUS);
	assign mapped = isTx || isRx || isConfig || isTimeout || isStatus;

	// Rejects: no transmit credit, empty receive queue, RX written, bad offset
	assign PSLVERR = (writeAccess && isTx && (txCredits == '0))
		|| (readAccess && isRx && (rxLevel == '0))
		|| (writeAccess && isRx)
		|| (access && !mapped);

	// Queue strobes only fire on accepted accesses
	assign txPush = writeAccess && isTx && (txCredits != '0);
	assign txWriteData = PWDATA[$bits(apbI2cPkg::cmdWordT)-1:0];
	assign rxPop = readAccess && isRx && (rxLevel != '0);

	////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			configReg <= '0;
			timeoutReg <= '0;
		end
		else if (writeAccess && isConfig)
			configReg <= PWDATA[$bits(apbI2cPkg::i2cRegT)-1:0];
		else if (writeAccess && isTimeout)
			timeoutReg <= PWDATA[$bits(apbI2cPkg::i2cRegT)-1:0];
	end

	// One credit per free transmit slot
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			txCredits <= CNT_W'(FIFO_DEPTH);
		else if (txPush && !txCreditReturn)
			txCredits <= txCredits - 1'b1;
		else if (!txPush && txCreditReturn)
			txCredits <= txCredits + 1'b1;
	end

	// Sticky error, a new event wins over a clear in the same cycle
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			errorFlag <= 1'b0;
		else if (nackSeen || timeoutSeen)
			errorFlag <= 1'b1;
		else if (writeAccess && isStatus)
			errorFlag <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////
	// Read data and interrupts
	////////////////////////////////////////////////////////////////////

	always_comb
	begin
		statusWord = '0;
		statusWord[0] = errorFlag;
		statusWord[1] = busy;
		statusWord[7:4] = 4'(txCredits);
		statusWord[11:8] = 4'(rxLevel);
	end

	// Read mux, zero outside a read access
	always_comb
	begin
		PRDATA = '0;
		if (readAccess)
		begin
			if (isRx && (rxLevel != '0))
				PRDATA = apbI2cPkg::apbDataT'(rxHeadByte);
			else if (isConfig)
				PRDATA = apbI2cPkg::apbDataT'(configReg);
			else if (isTimeout)
				PRDATA = apbI2cPkg::apbDataT'(timeoutReg);
			else if (isStatus)
				PRDATA = statusWord;
		end
	end

	// Transmit queue empty when every credit is home
	assign intTx = (txCredits == CNT_W'(FIFO_DEPTH));
	assign intRx = (rxLevel != '0);

endmodule

//--- creditFifo.sv
`timescale 1ns/1ns

/*
 * Circular queue with a level counter and one credit pulse per pop
 */
module creditFifo #(
	parameter int FIFO_DEPTH = 4,
	parameter int CNT_W = 3,
	parameter int WIDTH = 8
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic push,
	input  logic [WIDTH-1:0] pushData,
	input  logic pop,
	output logic [WIDTH-1:0] headData,
	output logic valid,
	output logic [CNT_W-1:0] level,
	output logic creditReturn
);

	// Pointer width, at least one bit for a single-entry queue
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;

	// Advance a pointer and wrap at the last entry
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Storage array
	always_ff @(posedge PCLK)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// Pointers, level and credit pulse
	// Credit holder upstream guarantees a free slot on every push
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			if (push && !pop)
				level <= level + 1'b1;
			else if (pop && !push)
				level <= level - 1'b1;
			// Freed slot goes back to the holder one cycle after the pop
			creditReturn <= pop;
		end
	end

	// Head entry is visible while the queue holds anything
	assign headData = mem[rdPtr];
	assign valid = (level != '0);

endmodule

//--- i2cEngine.sv
`timescale 1ns/1ns

/*
 * I2C byte engine: start, data, ACK and stop sequencing on SCL and SDA,
 * command fetch from the transmit queue and receive credit tracking
 */
module i2cEngine #(
	parameter int FIFO_DEPTH = 4,
	parameter int CNT_W = 3
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic txValid,
	input  apbI2cPkg::cmdWordT txHeadWord,
	input  logic rxCreditReturn,
	input  apbI2cPkg::i2cRegT configReg,
	input  apbI2cPkg::i2cRegT timeoutReg,
	input  logic sdaIn,
	output logic txPop,
	output logic rxPush,
	output apbI2cPkg::rxByteT rxPushByte,
	output logic nackSeen,
	output logic timeoutSeen,
	output logic busy,
	output logic scl,
	output logic sdaOut
);

	apbI2cPkg::engineStateT state;
	apbI2cPkg::i2cRegT halfCnt;
	apbI2cPkg::i2cRegT halfLen;
	apbI2cPkg::i2cRegT midPoint;
	apbI2cPkg::i2cRegT waitCnt;
	apbI2cPkg::cmdWordT cmdReg;
	apbI2cPkg::rxByteT shiftReg;
	logic [2:0] bitCnt;
	logic [CNT_W-1:0] rxCredits;
	logic startPhase;
	logic tick;
	logic atStart;
	logic atMid;
	logic isRead;
	logic isStop;
	logic creditReady;
	logic takeCredit;
	logic waitExpired;

	////////////////////////////////////////////////////////////////////
	// Half-period timing
	////////////////////////////////////////////////////////////////////

	// CONFIG of zero behaves as one
	assign halfLen = (configReg == '0) ? 14'd1 : configReg;
	assign midPoint = halfLen >> 1;
	// Last cycle of a half-period, also catches a CONFIG shrink mid-phase
	assign tick = (halfCnt >= halfLen - 1'b1);
	assign atStart = (halfCnt == '0);
	assign atMid = (halfCnt == midPoint);

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			halfCnt <= '0;
		else if ((state == apbI2cPkg::IDLE) || (state == apbI2cPkg::WAIT_CREDIT) || tick)
			halfCnt <= '0;
		else
			halfCnt <= halfCnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////
	// Command flags and receive credits
	////////////////////////////////////////////////////////////////////

	assign isRead = cmdReg[apbI2cPkg::CMD_READ_BIT];
	assign isStop = cmdReg[apbI2cPkg::CMD_STOP_BIT];
	assign creditReady = (rxCredits != '0);
	assign busy = (state != apbI2cPkg::IDLE);

	// Read byte handed over at the end of the ACK slot or once a credit arrives
	assign takeCredit = isRead && creditReady
		&& (((state == apbI2cPkg::ACK_HIGH) && tick) || (state == apbI2cPkg::WAIT_CREDIT));

	// TIMEOUT of zero waits forever
	assign waitExpired = (timeoutReg != '0) && (waitCnt == timeoutReg - 1'b1);

	// One credit per free receive slot
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			rxCredits <= CNT_W'(FIFO_DEPTH);
		else if (takeCredit && !rxCreditReturn)
			rxCredits <= rxCredits - 1'b1;
		else if (!takeCredit && rxCreditReturn)
			rxCredits <= rxCredits + 1'b1;
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
			waitCnt <= '0;
		else if (state == apbI2cPkg::WAIT_CREDIT)
			waitCnt <= waitCnt + 1'b1;
		else
			waitCnt <= '0;
	end

	// Command, shift register and outgoing byte
	// Shift register samples the bus on every bit, so writes just echo their data
	always_ff @(posedge PCLK)
	begin
		if ((state == apbI2cPkg::IDLE) && txValid)
		begin
			cmdReg <= txHeadWord;
			shiftReg <= txHeadWord[7:0];
		end
		else if ((state == apbI2cPkg::BIT_HIGH) && atMid)
			shiftReg <= {shiftReg[6:0], sdaIn};
		if (takeCredit)
			rxPushByte <= shiftReg;
	end

	////////////////////////////////////////////////////////////////////
	// Bus state machine
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= apbI2cPkg::IDLE;
			scl <= 1'b1;
			sdaOut <= 1'b1;
			startPhase <= 1'b0;
			bitCnt <= '0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
			nackSeen <= 1'b0;
			timeoutSeen <= 1'b0;
		end
		else
		begin
			// Single-cycle strobes
			txPop <= 1'b0;
			nackSeen <= 1'b0;
			timeoutSeen <= 1'b0;
			rxPush <= takeCredit;
			case (state)
				apbI2cPkg::IDLE:
				begin
					if (txValid)
					begin
						txPop <= 1'b1;
						bitCnt <= '0;
						startPhase <= 1'b0;
						if (txHeadWord[apbI2cPkg::CMD_START_BIT])
							state <= apbI2cPkg::START;
						else
						begin
							// Continue the transfer, SCL goes low first
							scl <= 1'b0;
							state <= apbI2cPkg::BIT_LOW;
						end
					end
				end
				apbI2cPkg::START:
				begin
					// First half releases SDA and raises SCL
					// Second half pulls SDA low under a high SCL
					if (atStart)
						sdaOut <= startPhase ? 1'b0 : 1'b1;
					if (tick)
					begin
						scl <= !startPhase;
						startPhase <= !startPhase;
						if (startPhase)
							state <= apbI2cPkg::BIT_LOW;
					end
				end
				apbI2cPkg::BIT_LOW:
				begin
					// Data changes one cycle into the low phase
					if (atStart)
						sdaOut <= isRead ? 1'b1 : shiftReg[7];
					if (tick)
					begin
						scl <= 1'b1;
						state <= apbI2cPkg::BIT_HIGH;
					end
				end
				apbI2cPkg::BIT_HIGH:
				begin
					if (tick)
					begin
						scl <= 1'b0;
						bitCnt <= bitCnt + 1'b1;
						state <= (bitCnt == 3'd7) ? apbI2cPkg::ACK_LOW : apbI2cPkg::BIT_LOW;
					end
				end
				apbI2cPkg::ACK_LOW:
				begin
					// Master ACKs a read unless it is the last, releases after a write
					if (atStart)
						sdaOut <= isRead ? isStop : 1'b1;
					if (tick)
					begin
						scl <= 1'b1;
						state <= apbI2cPkg::ACK_HIGH;
					end
				end
				apbI2cPkg::ACK_HIGH:
				begin
					if (atMid && !isRead && sdaIn)
						nackSeen <= 1'b1;
					if (tick)
					begin
						scl <= 1'b0;
						if (isRead && !creditReady)
							state <= apbI2cPkg::WAIT_CREDIT;
						else if (isStop)
							state <= apbI2cPkg::STOP_LOW;
						else
							state <= apbI2cPkg::IDLE;
					end
				end
				apbI2cPkg::WAIT_CREDIT:
				begin
					// SCL stays low until a receive slot frees up
					if (creditReady)
						state <= isStop ? apbI2cPkg::STOP_LOW : apbI2cPkg::IDLE;
					else if (waitExpired)
					begin
						timeoutSeen <= 1'b1;
						state <= apbI2cPkg::STOP_LOW;
					end
				end
				apbI2cPkg::STOP_LOW:
				begin
					if (atStart)
						sdaOut <= 1'b0;
					if (tick)
					begin
						scl <= 1'b1;
						state <= apbI2cPkg::STOP_HIGH;
					end
				end
				apbI2cPkg::STOP_HIGH:
				begin
					// SDA rises under a high SCL to end the transfer
					if (tick)
					begin
						sdaOut <= 1'b1;
						state <= apbI2cPkg::IDLE;
					end
				end
				default:
					state <= apbI2cPkg::IDLE;
			endcase
		end
	end

endmodule

//--- i2cSlaveModel.sv
`timescale 1ns/1ns

/*
 * Behavioral I2C slave for the testbench: ACK rules, read data rules and
 * a queue of byte directions announced by the testbench
 */
module i2cSlaveModel (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic scl,
	input  logic sda,
	input  logic dirPush,
	input  logic dirRead,
	output logic sdaOut
);

	logic sclPrev;
	logic sdaPrev;
	logic released;
	logic [7:0] shiftIn;
	logic [7:0] lastByte;
	logic [7:0] readByte;
	int bitCount;
	bit dirQueue[$];

	// Bus sampled on PCLK, so a half-period must span several PCLK cycles
	always @(posedge PCLK)
	begin
		bit readNow;
		readNow = (dirQueue.size() != 0) && dirQueue[0];
		if (!PRESETn)
		begin
			sclPrev <= 1'b1;
			sdaPrev <= 1'b1;
			sdaOut <= 1'b1;
			released = 1'b0;
			bitCount = 0;
			shiftIn = '0;
			lastByte = '0;
			readByte = '0;
			dirQueue.delete();
		end
		else
		begin
			// Direction of each accepted command, in queue order
			if (dirPush)
				dirQueue.push_back(dirRead);
			sclPrev <= scl;
			sdaPrev <= sda;
			if (sclPrev && scl && (sdaPrev != sda))
			begin
				// Start or stop condition resets the byte framing
				bitCount = 0;
				released = 1'b0;
				sdaOut <= 1'b1;
			end
			else if (!sclPrev && scl)
			begin
				// Rising SCL, sample data or the master's ACK
				if (bitCount < 8)
					shiftIn = {shiftIn[6:0], sda};
				if ((bitCount == 7) && !readNow)
					lastByte = shiftIn;
				if ((bitCount == 8) && readNow && sda)
					released = 1'b1;
				bitCount = bitCount + 1;
			end
			else if (sclPrev && !scl)
			begin
				// Falling SCL, byte done after the ACK slot
				if (bitCount == 9)
				begin
					bitCount = 0;
					if (dirQueue.size() != 0)
						void'(dirQueue.pop_front());
					readNow = (dirQueue.size() != 0) && dirQueue[0];
				end
				// Read data is the last byte on the bus plus one
				if ((bitCount == 0) && readNow && !released)
				begin
					readByte = 8'(lastByte + 8'd1);
					lastByte = readByte;
				end
				if (bitCount < 8)
					sdaOut <= (readNow && !released) ? readByte[7 - bitCount] : 1'b1;
				else if (bitCount == 8)
					sdaOut <= (!readNow && (lastByte != 8'hFF)) ? 1'b0 : 1'b1;
				else
					sdaOut <= 1'b1;
			end
		end
	end

endmodule

//--- runSim.sh
#!/bin/bash
# Build and run the APB I2C testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f apbI2c.f --top-module apbI2cTb -o simApbI2c > build.log 2>&1 \
	&& ./obj_dir/simApbI2c > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
